// ==== zx_ports_macros.svh ====
`ifndef ZX_PORTS_MACROS_SVH
`define ZX_PORTS_MACROS_SVH

// low address bytes
`define ZX_PORT_FE    8'hFE
`define ZX_PORT_FD    8'hFD
`define ZX_PORT_F7    8'hF7
`define ZX_PORT_CVX1  8'hFB
`define ZX_PORT_CVX2  8'hDD
`define ZX_PORT_SD0   8'h0F
`define ZX_PORT_SD1   8'h1F
`define ZX_PORT_SD2   8'h4F
`define ZX_PORT_SD3   8'h5F
`define ZX_PORT_XTRD  8'hEF
`define ZX_PORT_SDCFG 8'h77
`define ZX_PORT_SDDAT 8'h57

// extended port, full address
`define ZX_PORT_XT    16'h55FF

// value that opens the extended port
`define ZX_XT_KEY     8'hAA

// extended register indices
`define ZX_XT_BORDER  8'h00
`define ZX_XT_VCFG    8'h08

// clk cycles per sck half period
`define ZX_SPI_HALF   1

`endif

// ==== zx_ports_pkg.sv ====
package zx_ports_pkg;

	// decoded port of the current I/O cycle
	typedef enum logic [3:0]
	{
		none,
		fe,       // ula port, border and beeper
		fd_7ffd,  // memory paging
		f7_eff7,  // extended paging
		covox,    // FB and DD
		sd0,      // soundrive channels
		sd1,
		sd2,
		sd3,
		xt,       // full 16-bit match on 55FF
		xt_read,  // EF readback
		sd_cfg,   // sd chip select
		sd_dat    // spi data
	} port_sel_t;

	// lock sequence of the extended port
	typedef enum logic [1:0]
	{
		locked,
		addr_phase,
		data_phase
	} xt_state_t;

	typedef enum logic
	{
		idle,
		shift
	} spi_state_t;

endpackage

// ==== io_bus_if.sv ====
`timescale 1ns/1ps

interface io_bus_if;

	logic                    port_wr;  // one clk per new write
	logic                    port_rd;  // one clk per new read
	zx_ports_pkg::port_sel_t sel;
	logic [7:0]              hia;      // a[15:8]
	logic [7:0]              wdata;

	modport source
	(
		output port_wr,
		output port_rd,
		output sel,
		output hia,
		output wdata
	);

	modport sink
	(
		input port_wr,
		input port_rd,
		input sel,
		input hia,
		input wdata
	);

endinterface

// ==== io_cycle_decoder.sv ====
`timescale 1ns/1ps
`include "zx_ports_macros.svh"

module io_cycle_decoder
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        dos,
	input  logic [4:0]  keys_in,
	input  logic [5:0]  border,
	input  logic [7:0]  sd_rx,
	io_bus_if.source    bus,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit
);

	logic                    iowr_q;
	logic                    iord_q;
	logic                    port_wr_q;
	logic                    port_rd_q;
	zx_ports_pkg::port_sel_t port_sel;

	// strobe sampling, a pulse only on the first clk of a cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_q    <= 1'b0;
			iord_q    <= 1'b0;
			port_wr_q <= 1'b0;
			port_rd_q <= 1'b0;
		end
		else
		begin
			iowr_q    <= ~(iorq_n | wr_n);
			iord_q    <= ~(iorq_n | rd_n);
			port_wr_q <= ~iowr_q & ~iorq_n & ~wr_n;
			port_rd_q <= ~iord_q & ~iorq_n & ~rd_n;
		end
	end

	// address to port
	always_comb
	begin
		port_sel = zx_ports_pkg::none;
		if (a == `ZX_PORT_XT)
			port_sel = zx_ports_pkg::xt;
		else
		begin
			case (a[7:0])
				`ZX_PORT_FE:                port_sel = zx_ports_pkg::fe;
				`ZX_PORT_FD:                port_sel = zx_ports_pkg::fd_7ffd;
				`ZX_PORT_F7:                port_sel = zx_ports_pkg::f7_eff7;
				`ZX_PORT_CVX1, `ZX_PORT_CVX2: port_sel = zx_ports_pkg::covox;
				`ZX_PORT_SD0:   port_sel = dos ? zx_ports_pkg::none : zx_ports_pkg::sd0;
				`ZX_PORT_SD1:   port_sel = dos ? zx_ports_pkg::none : zx_ports_pkg::sd1;
				`ZX_PORT_SD2:   port_sel = dos ? zx_ports_pkg::none : zx_ports_pkg::sd2;
				`ZX_PORT_SD3:   port_sel = dos ? zx_ports_pkg::none : zx_ports_pkg::sd3;
				`ZX_PORT_XTRD:  port_sel = zx_ports_pkg::xt_read;
				`ZX_PORT_SDCFG: port_sel = zx_ports_pkg::sd_cfg;
				`ZX_PORT_SDDAT: port_sel = zx_ports_pkg::sd_dat;
				default:        port_sel = zx_ports_pkg::none;
			endcase
		end
	end

	assign porthit = (port_sel != zx_ports_pkg::none);

	// FD reads belong to the AY outside
	assign dataout = porthit & ~iorq_n & ~rd_n & (port_sel != zx_ports_pkg::fd_7ffd);

	always_comb
	begin
		case (port_sel)
			zx_ports_pkg::fe:      dout = {3'b100, keys_in};  // tape in reads 0
			zx_ports_pkg::xt_read: dout = {2'b00, border};
			zx_ports_pkg::sd_cfg:  dout = 8'h00;  // card present, writable
			zx_ports_pkg::sd_dat:  dout = sd_rx;
			default:               dout = 8'hFF;
		endcase
	end

	assign bus.port_wr = port_wr_q;
	assign bus.port_rd = port_rd_q;
	assign bus.sel     = port_sel;
	assign bus.hia     = a[15:8];
	assign bus.wdata   = din;

endmodule

// ==== paging_regs.sv ====
`timescale 1ns/1ps

module paging_regs
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        mreq_n,
	input  logic        m1_n,
	input  logic [15:0] a,
	input  logic [1:0]  rstrom,
	io_bus_if.sink      bus,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic        dos
);

	logic [7:0] p7ffd_int;  // bit 4 is the rom select
	logic [7:0] peff7_int;
	logic       boot;       // first clk after reset release
	logic       block1m;
	logic       block7ffd;
	logic       wr_7ffd;
	logic       wr_eff7;

	assign block1m   = peff7_int[2];
	assign block7ffd = p7ffd_int[5] & block1m;  // 48k lock

	assign wr_7ffd = bus.port_wr && (bus.sel == zx_ports_pkg::fd_7ffd) && !bus.hia[7] &&
		!block7ffd;
	assign wr_eff7 = bus.port_wr && (bus.sel == zx_ports_pkg::f7_eff7) && !bus.hia[4];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			boot      <= 1'b1;
			p7ffd_int <= 8'h00;
			peff7_int <= 8'h00;
			dos       <= 1'b0;
		end
		else
		begin
			boot <= 1'b0;
			if (boot)
			begin
				p7ffd_int[4] <= rstrom[0];  // strap picks the start rom
				dos          <= ~rstrom[1];
			end
			else
			begin
				if (wr_7ffd)
					p7ffd_int <= bus.wdata;
				if (wr_eff7)
					peff7_int <= bus.wdata;

				// dos rom trap on opcode fetch
				if (!mreq_n && !m1_n)
				begin
					if ((a[15:8] == 8'h3D) && p7ffd_int[4])
						dos <= 1'b1;
					else if (a[15:14] != 2'b00)
						dos <= 1'b0;
				end
			end
		end
	end

	assign p7ffd = {(block1m ? 3'b000 : p7ffd_int[7:5]), p7ffd_int[4:0]};

	// 1M block hides the extended page bits
	assign peff7 = block1m ?
		{peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]} : peff7_int;

endmodule

// ==== sound_dac_regs.sv ====
`timescale 1ns/1ps

module sound_dac_regs
(
	input  logic       clk,
	input  logic       rst_n,
	io_bus_if.sink     bus,
	output logic [7:0] psd0,
	output logic [7:0] psd1,
	output logic [7:0] psd2,
	output logic [7:0] psd3
);

	logic [7:0] beep;

	assign beep = {8{bus.wdata[4]}};  // beeper drives full scale

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			psd0 <= 8'h00;
			psd1 <= 8'h00;
			psd2 <= 8'h00;
			psd3 <= 8'h00;
		end
		else if (bus.port_wr)
		begin
			case (bus.sel)
				zx_ports_pkg::fe:
				begin
					psd0 <= beep;
					psd1 <= beep;
					psd2 <= beep;
					psd3 <= beep;
				end
				zx_ports_pkg::covox:  // mono, all channels
				begin
					psd0 <= bus.wdata;
					psd1 <= bus.wdata;
					psd2 <= bus.wdata;
					psd3 <= bus.wdata;
				end
				zx_ports_pkg::sd0: psd0 <= bus.wdata;
				zx_ports_pkg::sd1: psd1 <= bus.wdata;
				zx_ports_pkg::sd2: psd2 <= bus.wdata;
				zx_ports_pkg::sd3: psd3 <= bus.wdata;
				default: ;
			endcase
		end
	end

endmodule

// ==== video_config_regs.sv ====
`timescale 1ns/1ps
`include "zx_ports_macros.svh"

module video_config_regs
(
	input  logic       clk,
	input  logic       rst_n,
	io_bus_if.sink     bus,
	output logic [5:0] border,
	output logic [7:0] vcfg
);

	zx_ports_pkg::xt_state_t xt_state;
	logic [7:0]              xt_idx;  // register index latched in addr phase
	logic                    xt_wr;
	logic                    fe_wr;

	assign xt_wr = bus.port_wr && (bus.sel == zx_ports_pkg::xt);
	assign fe_wr = bus.port_wr && (bus.sel == zx_ports_pkg::fe);

	always_ff @(posedge clk)
	begin
		if (xt_wr && (xt_state == zx_ports_pkg::addr_phase))
			xt_idx <= bus.wdata;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			xt_state <= zx_ports_pkg::locked;
			border   <= 6'd0;
			vcfg     <= 8'h00;
		end
		else
		begin
			// classic border, spread over the 6-bit palette
			if (fe_wr)
				border <= {bus.wdata[1], 1'b0, bus.wdata[2], 1'b0, bus.wdata[0], 1'b0};

			if (xt_wr)
			begin
				case (xt_state)
					zx_ports_pkg::locked:
						if (bus.wdata == `ZX_XT_KEY)
							xt_state <= zx_ports_pkg::addr_phase;
					zx_ports_pkg::addr_phase:
						xt_state <= zx_ports_pkg::data_phase;
					default:
					begin
						if (xt_idx == `ZX_XT_BORDER)
							border <= bus.wdata[5:0];
						else if (xt_idx == `ZX_XT_VCFG)
							vcfg <= bus.wdata;
						xt_state <= zx_ports_pkg::locked;
					end
				endcase
			end
			else if (bus.port_wr)
				xt_state <= zx_ports_pkg::locked;  // any other write closes the sequence
		end
	end

endmodule

// ==== sd_spi_port.sv ====
`timescale 1ns/1ps
`include "zx_ports_macros.svh"

module sd_spi_port
(
	input  logic       clk,
	input  logic       rst_n,
	io_bus_if.sink     bus,
	input  logic       sd_miso,
	output logic       sd_cs_n,
	output logic       sd_sck,
	output logic       sd_mosi,
	output logic       sd_busy,
	output logic [7:0] sd_rx
);

	localparam int DIV_W = $clog2(`ZX_SPI_HALF + 1);

	zx_ports_pkg::spi_state_t state;
	logic [DIV_W-1:0]         div_cnt;
	logic [3:0]               half_cnt;  // 16 sck half periods per byte
	logic [7:0]               shreg;
	logic                     miso_q;
	logic                     half_end;
	logic                     go;

	assign half_end = (div_cnt == DIV_W'(`ZX_SPI_HALF - 1));

	// busy accesses are dropped
	assign go = (bus.port_wr || bus.port_rd) && (bus.sel == zx_ports_pkg::sd_dat) &&
		(state == zx_ports_pkg::idle);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sd_cs_n  <= 1'b1;
			state    <= zx_ports_pkg::idle;
			div_cnt  <= '0;
			half_cnt <= 4'd0;
			sd_sck   <= 1'b0;
			shreg    <= 8'hFF;
			sd_rx    <= 8'h00;
		end
		else
		begin
			if (bus.port_wr && (bus.sel == zx_ports_pkg::sd_cfg))
				sd_cs_n <= bus.wdata[1];

			if (go)
			begin
				state    <= zx_ports_pkg::shift;
				shreg    <= bus.port_wr ? bus.wdata : 8'hFF;  // reads clock out FF
				div_cnt  <= '0;
				half_cnt <= 4'd0;
			end
			else if (state == zx_ports_pkg::shift)
			begin
				div_cnt <= half_end ? '0 : div_cnt + 1'b1;
				if (half_end)
				begin
					sd_sck   <= ~sd_sck;
					half_cnt <= half_cnt + 4'd1;
					if (sd_sck)
						shreg <= {shreg[6:0], miso_q};  // falling edge, next bit out
					if (half_cnt == 4'd15)
					begin
						state <= zx_ports_pkg::idle;
						sd_rx <= {shreg[6:0], miso_q};
					end
				end
			end
		end
	end

	// miso taken on the rising sck edge
	always_ff @(posedge clk)
	begin
		if ((state == zx_ports_pkg::shift) && half_end && !sd_sck)
			miso_q <= sd_miso;
	end

	assign sd_mosi = shreg[7];
	assign sd_busy = (state == zx_ports_pkg::shift);

endmodule

// ==== zx_ports_top.sv ====
`timescale 1ns/1ps

module zx_ports_top
(
	input  logic        clk,
	input  logic        rst_n,

	// z80 bus
	input  logic [15:0] a,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        m1_n,
	input  logic        rd_n,
	input  logic        wr_n,

	input  logic [4:0]  keys_in,
	input  logic [1:0]  rstrom,

	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic        dos,
	output logic [5:0]  border,
	output logic [7:0]  vcfg,
	output logic [7:0]  psd0,
	output logic [7:0]  psd1,
	output logic [7:0]  psd2,
	output logic [7:0]  psd3,

	// sd card
	output logic        sd_cs_n,
	output logic        sd_sck,
	output logic        sd_mosi,
	input  logic        sd_miso,
	output logic        sd_busy
);

	logic [7:0] sd_rx;

	io_bus_if io_bus ();

	io_cycle_decoder u_decoder
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.a       (a),
		.din     (din),
		.dos     (dos),
		.keys_in (keys_in),
		.border  (border),
		.sd_rx   (sd_rx),
		.bus     (io_bus.source),
		.dout    (dout),
		.dataout (dataout),
		.porthit (porthit)
	);

	paging_regs u_paging
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.mreq_n (mreq_n),
		.m1_n   (m1_n),
		.a      (a),
		.rstrom (rstrom),
		.bus    (io_bus.sink),
		.p7ffd  (p7ffd),
		.peff7  (peff7),
		.dos    (dos)
	);

	sound_dac_regs u_dac
	(
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (io_bus.sink),
		.psd0  (psd0),
		.psd1  (psd1),
		.psd2  (psd2),
		.psd3  (psd3)
	);

	video_config_regs u_video
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.bus    (io_bus.sink),
		.border (border),
		.vcfg   (vcfg)
	);

	sd_spi_port u_sd
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.bus     (io_bus.sink),
		.sd_miso (sd_miso),
		.sd_cs_n (sd_cs_n),
		.sd_sck  (sd_sck),
		.sd_mosi (sd_mosi),
		.sd_busy (sd_busy),
		.sd_rx   (sd_rx)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic rst_n
);

	// 4 ns period
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;  // released just after the 4th edge
	end

endmodule

// ==== tb_zx_ports.sv ====
`timescale 1ns/1ps
`include "zx_ports_macros.svh"

module tb_zx_ports;

	// some 80 bus cycles of 5 clk plus three 16 clk spi transfers
	localparam int CYCLE_LIMIT = 4000;

	typedef struct packed
	{
		logic [7:0]      r7ffd;   // raw register before masking
		logic [7:0]      reff7;
		logic [5:0]      border;
		logic [7:0]      vcfg;
		logic [3:0][7:0] psd;
		logic            cs_n;
		logic [1:0]      xt_ph;   // 0 locked, 1 index next, 2 data next
		logic [7:0]      xt_idx;
		logic            dos;
	} model_t;

	logic        clk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic        iorq_n;
	logic        mreq_n;
	logic        m1_n;
	logic        rd_n;
	logic        wr_n;
	logic [4:0]  keys_in;
	logic [1:0]  rstrom;
	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic        dos;
	logic [5:0]  border;
	logic [7:0]  vcfg;
	logic [7:0]  psd0;
	logic [7:0]  psd1;
	logic [7:0]  psd2;
	logic [7:0]  psd3;
	logic        sd_cs_n;
	logic        sd_sck;
	logic        sd_mosi;
	logic        sd_miso;
	logic        sd_busy;

	model_t      model;
	logic [7:0]  exp_rx;      // byte the spi engine should hold
	logic [31:0] seed_val;
	logic [7:0]  x;
	logic [7:0]  y;
	int          cycles = 0;
	int          sck_rises = 0;
	event        cycle_done;

	assign sd_miso = sd_mosi;  // loopback

	tb_clock_gen u_clk
	(
		.clk   (clk),
		.rst_n (rst_n)
	);

	zx_ports_top UUT
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.a       (a),
		.din     (din),
		.dout    (dout),
		.dataout (dataout),
		.porthit (porthit),
		.iorq_n  (iorq_n),
		.mreq_n  (mreq_n),
		.m1_n    (m1_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.keys_in (keys_in),
		.rstrom  (rstrom),
		.p7ffd   (p7ffd),
		.peff7   (peff7),
		.dos     (dos),
		.border  (border),
		.vcfg    (vcfg),
		.psd0    (psd0),
		.psd1    (psd1),
		.psd2    (psd2),
		.psd3    (psd3),
		.sd_cs_n (sd_cs_n),
		.sd_sck  (sd_sck),
		.sd_mosi (sd_mosi),
		.sd_miso (sd_miso),
		.sd_busy (sd_busy)
	);

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $urandom();
		return r[7:0];
	endfunction

	// expected register state after one I/O write
	function automatic model_t apply_write(model_t s, logic [15:0] addr, logic [7:0] data);
		logic blocked;
		blocked = s.r7ffd[5] & s.reff7[2];  // 48k lock
		if (addr == `ZX_PORT_XT)
		begin
			case (s.xt_ph)
				2'd0:
					if (data == `ZX_XT_KEY)
						s.xt_ph = 2'd1;
				2'd1:
				begin
					s.xt_idx = data;
					s.xt_ph  = 2'd2;
				end
				default:
				begin
					if (s.xt_idx == `ZX_XT_BORDER)
						s.border = data[5:0];
					else if (s.xt_idx == `ZX_XT_VCFG)
						s.vcfg = data;
					s.xt_ph = 2'd0;
				end
			endcase
		end
		else
		begin
			s.xt_ph = 2'd0;  // any other write relocks
			case (addr[7:0])
				`ZX_PORT_FE:
				begin
					s.border = {data[1], 1'b0, data[2], 1'b0, data[0], 1'b0};
					s.psd    = {4{{8{data[4]}}}};
				end
				`ZX_PORT_FD:
					if (!addr[15] && !blocked)
						s.r7ffd = data;
				`ZX_PORT_F7:
					if (!addr[12])
						s.reff7 = data;
				`ZX_PORT_CVX1, `ZX_PORT_CVX2:
					s.psd = {4{data}};
				`ZX_PORT_SD0:
					if (!s.dos)
						s.psd[0] = data;
				`ZX_PORT_SD1:
					if (!s.dos)
						s.psd[1] = data;
				`ZX_PORT_SD2:
					if (!s.dos)
						s.psd[2] = data;
				`ZX_PORT_SD3:
					if (!s.dos)
						s.psd[3] = data;
				`ZX_PORT_SDCFG:
					s.cs_n = data[1];
				default: ;
			endcase
		end
		return s;
	endfunction

	// dos trap on an opcode fetch
	function automatic model_t apply_fetch(model_t s, logic [15:0] addr);
		if ((addr[15:8] == 8'h3D) && s.r7ffd[4])
			s.dos = 1'b1;
		else if (addr >= 16'h4000)
			s.dos = 1'b0;
		return s;
	endfunction

	function automatic logic [7:0] exp_p7ffd(model_t s);
		return s.reff7[2] ? {3'b000, s.r7ffd[4:0]} : s.r7ffd;
	endfunction

	function automatic logic [7:0] exp_peff7(model_t s);
		return s.reff7[2] ? (s.reff7 & 8'hB1) : s.reff7;  // keeps 7, 5, 4, 0
	endfunction

	// {porthit, dataout, dout} of an I/O read
	function automatic logic [9:0] read_expect(model_t s, logic [15:0] addr, logic [4:0] keys,
		logic [7:0] rx);
		logic       hit;
		logic [7:0] data;
		hit  = 1'b1;
		data = 8'hFF;
		if (addr != `ZX_PORT_XT)
		begin
			case (addr[7:0])
				`ZX_PORT_FE:    data = {3'b100, keys};
				`ZX_PORT_FD, `ZX_PORT_F7, `ZX_PORT_CVX1, `ZX_PORT_CVX2: ;
				`ZX_PORT_SD0, `ZX_PORT_SD1, `ZX_PORT_SD2, `ZX_PORT_SD3:
					hit = !s.dos;
				`ZX_PORT_XTRD:  data = {2'b00, s.border};
				`ZX_PORT_SDCFG: data = 8'h00;
				`ZX_PORT_SDDAT: data = rx;
				default:        hit = 1'b0;
			endcase
		end
		return {hit, hit && (addr[7:0] != `ZX_PORT_FD), data};
	endfunction

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// every task starts and ends 1 ns after a rising edge
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		model = apply_write(model, addr, data);
		-> cycle_done;
	endtask

	task automatic io_read(input logic [15:0] addr);
		logic [9:0] e;
		e      = read_expect(model, addr, keys_in, exp_rx);
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		@(posedge clk);
		#1;
		check("porthit", 8'(porthit), 8'(e[9]));
		check("dataout", 8'(dataout), 8'(e[8]));
		check("dout", dout, e[7:0]);
		repeat (2) @(posedge clk);
		#1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		-> cycle_done;
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		a      = addr;
		mreq_n = 1'b0;
		m1_n   = 1'b0;
		@(posedge clk);
		#1;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		@(posedge clk);
		#1;
		model = apply_fetch(model, addr);
		-> cycle_done;
	endtask

	task automatic wait_spi_idle();
		int n;
		n = 0;
		while (sd_busy && (n < 100))
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (sd_busy)
		begin
			$display("SPI transfer did not finish within 100 clocks");
			$display("Some tests failed");
			$fatal(1, "sd_busy stuck high");
		end
	endtask

	// sck edges as the card sees them
	always @(posedge sd_sck)
		sck_rises++;

	// registered outputs against the model
	always @(cycle_done)
	begin
		check("p7ffd", p7ffd, exp_p7ffd(model));
		check("peff7", peff7, exp_peff7(model));
		check("border", 8'(border), 8'(model.border));
		check("vcfg", vcfg, model.vcfg);
		check("psd0", psd0, model.psd[0]);
		check("psd1", psd1, model.psd[1]);
		check("psd2", psd2, model.psd[2]);
		check("psd3", psd3, model.psd[3]);
		check("sd_cs_n", 8'(sd_cs_n), 8'(model.cs_n));
		check("dos", 8'(dos), 8'(model.dos));
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		a       = 16'h0000;
		din     = 8'h00;
		iorq_n  = 1'b1;
		mreq_n  = 1'b1;
		m1_n    = 1'b1;
		rd_n    = 1'b1;
		wr_n    = 1'b1;
		keys_in = 5'h00;
		rstrom  = 2'b10;  // rom bit 0 and dos off
		seed_val = $urandom(32'h949a_c53c);

		model          = '0;
		model.cs_n     = 1'b1;
		model.dos      = ~rstrom[1];
		model.r7ffd[4] = rstrom[0];
		exp_rx         = 8'h00;

		@(posedge rst_n);
		repeat (2) @(posedge clk);
		#1;
		check("dataout", 8'(dataout), 8'h00);
		check("sd_busy", 8'(sd_busy), 8'h00);
		check("sd_sck", 8'(sd_sck), 8'h00);
		-> cycle_done;

		repeat (12)
		begin
			io_write({8'h7F, `ZX_PORT_FD}, rand_byte());
			io_write({8'hEF, `ZX_PORT_F7}, rand_byte());
		end
		io_write({8'hEF, `ZX_PORT_F7}, 8'h00);
		io_write({8'h7F, `ZX_PORT_FD}, 8'h3F);
		io_write({8'hEF, `ZX_PORT_F7}, 8'h04);  // lock engages
		io_write({8'h7F, `ZX_PORT_FD}, rand_byte());
		io_write({8'hEF, `ZX_PORT_F7}, 8'hFF);
		io_write({8'h7F, `ZX_PORT_FD}, 8'h00);
		io_write({8'hEF, `ZX_PORT_F7}, 8'h00);
		io_write({8'h7F, `ZX_PORT_FD}, 8'hC5);
		io_write({8'hFF, `ZX_PORT_FD}, rand_byte());  // ay register select
		io_write({8'hFF, `ZX_PORT_F7}, rand_byte());

		repeat (3) io_write({8'h00, `ZX_PORT_FE}, rand_byte());
		io_write({8'h00, `ZX_PORT_CVX1}, rand_byte());
		io_write({8'h00, `ZX_PORT_CVX2}, rand_byte());
		io_write({8'h00, `ZX_PORT_SD0}, rand_byte());
		io_write({8'h00, `ZX_PORT_SD1}, rand_byte());
		io_write({8'h00, `ZX_PORT_SD2}, rand_byte());
		io_write({8'h00, `ZX_PORT_SD3}, rand_byte());
		io_write({8'h00, `ZX_PORT_FE}, 8'h10);

		io_write(`ZX_PORT_XT, `ZX_XT_KEY);
		io_write(`ZX_PORT_XT, `ZX_XT_BORDER);
		io_write(`ZX_PORT_XT, rand_byte());
		io_write(`ZX_PORT_XT, `ZX_XT_KEY);
		io_write(`ZX_PORT_XT, `ZX_XT_VCFG);
		io_write(`ZX_PORT_XT, rand_byte());
		io_write(`ZX_PORT_XT, `ZX_XT_KEY);
		io_write(16'h00FF, rand_byte());
		io_write(`ZX_PORT_XT, `ZX_XT_BORDER);
		io_write(`ZX_PORT_XT, 8'h3C);
		io_write(`ZX_PORT_XT, `ZX_XT_KEY);
		io_write(`ZX_PORT_XT, `ZX_XT_VCFG);
		io_write(16'h00FF, rand_byte());
		io_write(`ZX_PORT_XT, 8'h3C);

		x = rand_byte();
		keys_in = x[4:0];
		io_read({8'h00, `ZX_PORT_FE});
		io_read({8'h00, `ZX_PORT_XTRD});
		io_read({8'h00, `ZX_PORT_SDCFG});
		io_read(16'h0033);
		io_read({8'h7F, `ZX_PORT_FD});
		io_read(`ZX_PORT_XT);

		io_write({8'h00, `ZX_PORT_SDCFG}, 8'h00);
		x = rand_byte();
		y = ~x;
		io_write({8'h00, `ZX_PORT_SDDAT}, x);
		check("sd_busy", 8'(sd_busy), 8'h01);
		io_write({8'h00, `ZX_PORT_SDDAT}, y);  // dropped while the engine is busy
		wait_spi_idle();
		exp_rx = x;
		io_read({8'h00, `ZX_PORT_SDDAT});  // also clocks out FF
		wait_spi_idle();
		exp_rx = 8'hFF;
		io_read({8'h00, `ZX_PORT_SDDAT});
		wait_spi_idle();
		check("sd_sck", 8'(sd_sck), 8'h00);
		check("sd_sck rising edges", 8'(sck_rises), 8'd24);  // three transfers of 8 bits
		io_write({8'h00, `ZX_PORT_SDCFG}, 8'h02);

		io_write({8'hEF, `ZX_PORT_F7}, 8'h00);
		io_write({8'h7F, `ZX_PORT_FD}, 8'h00);
		m1_fetch(16'h3D00);  // rom bit clear so no trap
		io_write({8'h7F, `ZX_PORT_FD}, 8'h10);
		m1_fetch(16'h3D00);
		io_read({8'h00, `ZX_PORT_SD0});
		io_write({8'h00, `ZX_PORT_SD0}, rand_byte());
		m1_fetch(16'h8000);
		io_read({8'h00, `ZX_PORT_SD0});
		@(posedge clk);

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== zx_ports.f ====
+incdir+.
zx_ports_pkg.sv
io_bus_if.sv
io_cycle_decoder.sv
paging_regs.sv
sound_dac_regs.sv
video_config_regs.sv
sd_spi_port.sv
zx_ports_top.sv
tb_clock_gen.sv
tb_zx_ports.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the zx_ports testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f zx_ports.f \
	--top-module tb_zx_ports \
	-o sim_zx_ports

./obj_dir/sim_zx_ports
